/* verilog/icm_cfg_pkg.sv */
// ICM cache configuration
// widths and vector types shared by the get thread and its reorder buffer
// translation entries only, two entries per request tag

`default_nettype none

package icm_cfg_pkg;

    // default sizes, passed down from the top level
    localparam int REQ_TAG_NUM  = 32;
    localparam int SLOT_ENTRIES = 2;

    localparam int REQ_TAG_W     = 5;
    localparam int PART_CNT_W    = 2;
    localparam int PART_IDX_W    = 1;
    localparam int CACHE_ADDR_W  = 20;
    localparam int PHYS_ADDR_W   = 32;
    localparam int CACHE_ENTRY_W = 256;

    // reorder buffer slot index
    typedef logic [REQ_TAG_W-1:0]     req_tag_t;
    // parts needed or already collected for one tag
    typedef logic [PART_CNT_W-1:0]    part_cnt_t;
    // position of a part inside its slot
    typedef logic [PART_IDX_W-1:0]    part_idx_t;
    // cache address of a translation entry
    typedef logic [CACHE_ADDR_W-1:0]  cache_addr_t;
    // physical address, not interpreted here
    typedef logic [PHYS_ADDR_W-1:0]   phys_addr_t;
    // one cache entry
    typedef logic [CACHE_ENTRY_W-1:0] cache_entry_t;

endpackage

`default_nettype wire

/* verilog/icm_get_pkg.sv */
// ICM get thread types
// request header, hit item, cache fill and response layouts,
// and the state encoding of the get-processing FSM

`default_nettype none

package icm_get_pkg;

    import icm_cfg_pkg::*;

    // header carried by both request FIFOs and echoed in the response
    typedef struct packed {
        part_cnt_t   count_max;
        part_idx_t   count_index;
        req_tag_t    req_tag;
        phys_addr_t  phys_addr;
        cache_addr_t cache_addr;
    } get_req_head_t;

    // hit FIFO item, header plus the entry found in the cache
    typedef struct packed {
        get_req_head_t head;
        cache_entry_t  data;
    } hit_item_t;

    // fill request towards the cache after a miss
    typedef struct packed {
        cache_addr_t  addr;
        cache_entry_t data;
    } cache_set_req_t;

    // one response beat
    typedef struct packed {
        get_req_head_t head;
        cache_entry_t  data;
    } get_rsp_t;

    typedef enum logic [2:0] {
        IDLE,
        HIT,
        MISS,
        SET,
        RSP
    } proc_state_t;

endpackage

`default_nettype wire

/* verilog/reorder_buffer.sv */
// Reorder buffer
// one slot per request tag, each slot holds the entries of that tag
// and a count of the parts merged so far

`timescale 1ns/1ps
`default_nettype none

module reorder_buffer #(
    parameter int REQ_TAG_NUM  = icm_cfg_pkg::REQ_TAG_NUM,
    parameter int SLOT_ENTRIES = icm_cfg_pkg::SLOT_ENTRIES
) (
    input  wire                                          clk,
    input  wire                                          rst,

    input  wire icm_cfg_pkg::req_tag_t                   slot_tag,
    input  wire                                          wr_en,
    input  wire icm_cfg_pkg::part_idx_t                  wr_index,
    input  wire icm_cfg_pkg::cache_entry_t               wr_data,
    input  wire                                          clr_en,

    // read side, combinational on slot_tag
    output icm_cfg_pkg::part_cnt_t                       collected,
    output icm_cfg_pkg::cache_entry_t [SLOT_ENTRIES-1:0] slot_entries
);

    import icm_cfg_pkg::*;

    cache_entry_t  entry_mem [REQ_TAG_NUM][SLOT_ENTRIES];
    part_cnt_t     part_cnt  [REQ_TAG_NUM];

    // entry storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            entry_mem[slot_tag][wr_index] <= wr_data;
        end
    end

    // per-tag collected counts
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int t = 0; t < REQ_TAG_NUM; t++) begin
                part_cnt[t] <= '0;
            end
        end else if (clr_en) begin
            part_cnt[slot_tag] <= '0;
        end else if (wr_en) begin
            part_cnt[slot_tag] <= part_cnt[slot_tag] + 2'd1;
        end
    end

    assign collected = part_cnt[slot_tag];

    always_comb begin
        for (int i = 0; i < SLOT_ENTRIES; i++) begin
            slot_entries[i] = entry_mem[slot_tag][i];
        end
    end

    // merge and clear come from different controller states
    a_wr_clr_excl: assert property (@(posedge clk) disable iff (rst)
        !(wr_en && clr_en))
        else $error("merge and clear in the same cycle");

endmodule

`default_nettype wire

/* verilog/get_proc_ctrl.sv */
// Get thread controller
// picks a hit or miss item, merges its part into the reorder buffer,
// issues cache fills for misses and streams the completed slot out

`timescale 1ns/1ps
`default_nettype none

module get_proc_ctrl #(
    parameter int SLOT_ENTRIES = icm_cfg_pkg::SLOT_ENTRIES
) (
    input  wire                                          clk,
    input  wire                                          rst,

    output logic                                         req_hit_rd_en,
    input  wire icm_get_pkg::hit_item_t                  req_hit_dout,
    input  wire                                          req_hit_empty,

    output logic                                         req_miss_rd_en,
    input  wire icm_get_pkg::get_req_head_t              req_miss_dout,
    input  wire                                          req_miss_empty,

    input  wire                                          icm_entry_rsp_valid,
    input  wire icm_cfg_pkg::cache_entry_t               icm_entry_rsp_data,
    output logic                                         icm_entry_rsp_ready,

    output logic                                         cache_set_req_valid,
    output icm_get_pkg::cache_set_req_t                  cache_set_req,
    input  wire                                          cache_set_req_ready,

    output logic                                         icm_get_rsp_valid,
    output icm_get_pkg::get_rsp_t                        icm_get_rsp,
    input  wire                                          icm_get_rsp_ready,

    // reorder buffer side
    output icm_cfg_pkg::req_tag_t                        slot_tag,
    output logic                                         wr_en,
    output icm_cfg_pkg::part_idx_t                       wr_index,
    output icm_cfg_pkg::cache_entry_t                    wr_data,
    output logic                                         clr_en,
    input  wire icm_cfg_pkg::part_cnt_t                  collected,
    input  wire icm_cfg_pkg::cache_entry_t [SLOT_ENTRIES-1:0] slot_entries
);

    import icm_cfg_pkg::*;
    import icm_get_pkg::*;

    proc_state_t    cur_state;
    proc_state_t    next_state;

    // source of the item being worked on
    logic           is_hit_proc;
    logic           is_miss_proc;

    get_req_head_t  cur_head;
    logic           take_miss;
    logic           take_hit;
    logic           hit_full;
    logic           slot_full;
    logic           set_fire;
    logic           rsp_fire;
    logic           rsp_last;

    part_cnt_t      rsp_count;
    part_cnt_t      rsp_total;

    // a miss needs its entry on the memory port, so only then it wins
    assign take_miss = (cur_state == IDLE) && !req_miss_empty && icm_entry_rsp_valid;
    assign take_hit  = (cur_state == IDLE) && !take_miss && !req_hit_empty;

    assign cur_head = is_miss_proc ? req_miss_dout : req_hit_dout.head;

    // in HIT the count is read before this part lands
    assign hit_full  = part_cnt_t'(collected + 2'd1) == cur_head.count_max;
    // in SET the part of this miss is already counted
    assign slot_full = collected == cur_head.count_max;

    assign set_fire = (cur_state == SET) && cache_set_req_ready;
    assign rsp_fire = (cur_state == RSP) && icm_get_rsp_ready;
    assign rsp_last = rsp_fire && (part_cnt_t'(rsp_count + 2'd1) == rsp_total);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cur_state <= IDLE;
        end else begin
            cur_state <= next_state;
        end
    end

    always_comb begin
        next_state = cur_state;
        case (cur_state)
            IDLE: begin
                if (take_miss) begin
                    next_state = MISS;
                end else if (take_hit) begin
                    next_state = HIT;
                end
            end
            HIT:  next_state = hit_full ? RSP : IDLE;
            MISS: next_state = SET;
            SET: begin
                if (set_fire) begin
                    next_state = slot_full ? RSP : IDLE;
                end
            end
            RSP: begin
                if (rsp_last) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            is_hit_proc  <= 1'b0;
            is_miss_proc <= 1'b0;
        end else if (take_miss) begin
            is_hit_proc  <= 1'b0;
            is_miss_proc <= 1'b1;
        end else if (take_hit) begin
            is_hit_proc  <= 1'b1;
            is_miss_proc <= 1'b0;
        end
    end

    // beat counter and total, latched on the way into RSP
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rsp_count <= '0;
            rsp_total <= '0;
        end else if (cur_state != RSP && next_state == RSP) begin
            rsp_count <= '0;
            rsp_total <= cur_head.count_max;
        end else if (rsp_last) begin
            rsp_count <= '0;
        end else if (rsp_fire) begin
            rsp_count <= rsp_count + 2'd1;
        end
    end

    // slot access, the tag follows the current item
    assign slot_tag = cur_head.req_tag;
    assign wr_en    = (cur_state == HIT) || (cur_state == MISS);
    assign wr_index = cur_head.count_index;
    assign wr_data  = is_miss_proc ? icm_entry_rsp_data : req_hit_dout.data;
    assign clr_en   = rsp_last;

    // pops, either once the part is merged or after the last beat
    assign req_hit_rd_en  = ((cur_state == HIT) && !hit_full) || (rsp_last && is_hit_proc);
    assign req_miss_rd_en = (set_fire && !slot_full) || (rsp_last && is_miss_proc);

    // memory entry is released together with the fill handshake
    assign icm_entry_rsp_ready = set_fire;

    assign cache_set_req_valid = cur_state == SET;
    assign cache_set_req.addr  = cur_head.cache_addr;
    assign cache_set_req.data  = icm_entry_rsp_data;

    assign icm_get_rsp_valid = cur_state == RSP;
    assign icm_get_rsp.head  = cur_head;
    assign icm_get_rsp.data  = slot_entries[part_idx_t'(rsp_count)];

    a_wr_index_range: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> int'(wr_index) < SLOT_ENTRIES)
        else $error("part index beyond slot size");

    // fill request held until the cache takes it
    a_set_req_hold: assert property (@(posedge clk) disable iff (rst)
        cache_set_req_valid && !cache_set_req_ready
            |=> cache_set_req_valid && $stable(cache_set_req))
        else $error("fill request dropped before ready");

endmodule

`default_nettype wire

/* verilog/icm_get_proc.sv */
// ICM get-processing thread
// merges hit and miss parts per request tag and returns them
// as ordered response beats once a tag is complete

`timescale 1ns/1ps
`default_nettype none

module icm_get_proc #(
    parameter int REQ_TAG_NUM  = icm_cfg_pkg::REQ_TAG_NUM,
    parameter int SLOT_ENTRIES = icm_cfg_pkg::SLOT_ENTRIES
) (
    input  wire                               clk,
    input  wire                               rst,

    // hit FIFO
    output logic                              req_hit_rd_en,
    input  wire icm_get_pkg::hit_item_t       req_hit_dout,
    input  wire                               req_hit_empty,

    // miss FIFO
    output logic                              req_miss_rd_en,
    input  wire icm_get_pkg::get_req_head_t   req_miss_dout,
    input  wire                               req_miss_empty,

    // entry fetched from memory
    input  wire                               icm_entry_rsp_valid,
    input  wire icm_cfg_pkg::cache_entry_t    icm_entry_rsp_data,
    output logic                              icm_entry_rsp_ready,

    // cache fill
    output logic                              cache_set_req_valid,
    output icm_get_pkg::cache_set_req_t       cache_set_req,
    input  wire                               cache_set_req_ready,

    // get response
    output logic                              icm_get_rsp_valid,
    output icm_get_pkg::get_rsp_t             icm_get_rsp,
    input  wire                               icm_get_rsp_ready
);

    import icm_cfg_pkg::*;

    req_tag_t                         slot_tag;
    logic                             wr_en;
    part_idx_t                        wr_index;
    cache_entry_t                     wr_data;
    logic                             clr_en;
    part_cnt_t                        collected;
    cache_entry_t [SLOT_ENTRIES-1:0]  slot_entries;

    get_proc_ctrl #(
        .SLOT_ENTRIES (SLOT_ENTRIES)
    ) u_ctrl (
        .clk                 (clk),
        .rst                 (rst),
        .req_hit_rd_en       (req_hit_rd_en),
        .req_hit_dout        (req_hit_dout),
        .req_hit_empty       (req_hit_empty),
        .req_miss_rd_en      (req_miss_rd_en),
        .req_miss_dout       (req_miss_dout),
        .req_miss_empty      (req_miss_empty),
        .icm_entry_rsp_valid (icm_entry_rsp_valid),
        .icm_entry_rsp_data  (icm_entry_rsp_data),
        .icm_entry_rsp_ready (icm_entry_rsp_ready),
        .cache_set_req_valid (cache_set_req_valid),
        .cache_set_req       (cache_set_req),
        .cache_set_req_ready (cache_set_req_ready),
        .icm_get_rsp_valid   (icm_get_rsp_valid),
        .icm_get_rsp         (icm_get_rsp),
        .icm_get_rsp_ready   (icm_get_rsp_ready),
        .slot_tag            (slot_tag),
        .wr_en               (wr_en),
        .wr_index            (wr_index),
        .wr_data             (wr_data),
        .clr_en              (clr_en),
        .collected           (collected),
        .slot_entries        (slot_entries)
    );

    reorder_buffer #(
        .REQ_TAG_NUM  (REQ_TAG_NUM),
        .SLOT_ENTRIES (SLOT_ENTRIES)
    ) u_rob (
        .clk          (clk),
        .rst          (rst),
        .slot_tag     (slot_tag),
        .wr_en        (wr_en),
        .wr_index     (wr_index),
        .wr_data      (wr_data),
        .clr_en       (clr_en),
        .collected    (collected),
        .slot_entries (slot_entries)
    );

endmodule

`default_nettype wire

/* dv/tb_ref.svh */
// Testbench reference model
// expected response beats of a completed tag, and the xorshift
// generator behind the random stimulus

`ifndef TB_REF_SVH
`define TB_REF_SVH

logic [31:0] rng_state = 32'd62945;

// xorshift32 step on the shared state
function automatic logic [31:0] rand32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

function automatic cache_entry_t rand_entry();
    cache_entry_t e;
    for (int i = 0; i < 8; i++) begin
        e[i*32 +: 32] = rand32();
    end
    return e;
endfunction

// beat k of a tag: entry with count_index k, header of the last part merged
function automatic get_rsp_t ref_beat(
    input get_req_head_t [1:0] heads,
    input cache_entry_t [1:0]  datas,
    input int                  nparts,
    input int                  k
);
    get_rsp_t beat;
    beat.head = heads[nparts-1];
    beat.data = '0;
    for (int j = 0; j < nparts; j++) begin
        if (int'(heads[j].count_index) == k) begin
            beat.data = datas[j];
        end
    end
    return beat;
endfunction

`endif

/* dv/tb_icm_get_proc.sv */
// Testbench for the ICM get-processing thread
// hit, miss and memory ports modeled with queues
// every fill and response handshake compared against the reference beats

`timescale 1ns/1ps
`default_nettype none

module tb_icm_get_proc;

    import icm_cfg_pkg::*;
    import icm_get_pkg::*;

    localparam int TAGS           = REQ_TAG_NUM;
    localparam int RAND_SETS      = 40;
    localparam int TOTAL_PARTS    = 7 + 2 * RAND_SETS;
    localparam int TIMEOUT_CYCLES = 300 + 40 * TOTAL_PARTS;

    `include "tb_ref.svh"

    logic           clk;
    logic           rst;
    logic           req_hit_rd_en;
    hit_item_t      req_hit_dout;
    logic           req_hit_empty;
    logic           req_miss_rd_en;
    get_req_head_t  req_miss_dout;
    logic           req_miss_empty;
    logic           icm_entry_rsp_valid;
    cache_entry_t   icm_entry_rsp_data;
    logic           icm_entry_rsp_ready;
    logic           cache_set_req_valid;
    cache_set_req_t cache_set_req;
    logic           cache_set_req_ready;
    logic           icm_get_rsp_valid;
    get_rsp_t       icm_get_rsp;
    logic           icm_get_rsp_ready;

    // FIFO and memory contents with the head at index 0
    hit_item_t      hit_q[$];
    get_req_head_t  miss_q[$];
    cache_entry_t   mem_q[$];
    cache_set_req_t exp_fill_q[$];
    get_rsp_t       exp_rsp_q[TAGS][$];

    // parts of the open set of each tag in processing order
    get_req_head_t [1:0] sent_head [TAGS];
    cache_entry_t [1:0]  sent_data [TAGS];
    int             sent_n [TAGS];
    logic           tag_busy [TAGS];

    logic           bp_en;
    logic           prio_watch;
    req_tag_t       prio_tag;
    int             prio_fill_base;
    int             errors;
    int             rsp_seen;
    int             fill_seen;
    int             cycle_cnt;

    icm_get_proc UUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic drive_ports();
        logic [31:0] r;
        r = rand32();
        req_hit_empty       = hit_q.size() == 0;
        req_hit_dout        = (hit_q.size() != 0) ? hit_q[0] : '0;
        req_miss_empty      = miss_q.size() == 0;
        req_miss_dout       = (miss_q.size() != 0) ? miss_q[0] : '0;
        icm_entry_rsp_valid = mem_q.size() != 0;
        icm_entry_rsp_data  = (mem_q.size() != 0) ? mem_q[0] : '0;
        cache_set_req_ready = bp_en ? r[0] : 1'b1;
        icm_get_rsp_ready   = bp_en ? r[1] : 1'b1;
    endtask

    // FIFO pops on the edge and the new head shows up 1 ns later
    always @(posedge clk) begin
        if (req_hit_rd_en && hit_q.size() == 0) begin
            $display("hit FIFO read while empty");
            errors++;
        end else if (req_hit_rd_en) begin
            void'(hit_q.pop_front());
        end
        if (req_miss_rd_en && miss_q.size() == 0) begin
            $display("miss FIFO read while empty");
            errors++;
        end else if (req_miss_rd_en) begin
            void'(miss_q.pop_front());
        end
        if (icm_entry_rsp_valid && icm_entry_rsp_ready) begin
            void'(mem_q.pop_front());
        end
        #1;
        drive_ports();
    end

    task automatic check_fill();
        cache_set_req_t exp;
        if (!icm_entry_rsp_ready) begin
            $display("memory entry not released with the fill handshake");
            errors++;
        end
        if (exp_fill_q.size() == 0) begin
            $display("unexpected cache fill request at address %h", cache_set_req.addr);
            errors++;
        end else begin
            exp = exp_fill_q.pop_front();
            if (cache_set_req.addr !== exp.addr) begin
                $display("FAIL cache_set_req.addr got %h expected %h",
                         cache_set_req.addr, exp.addr);
                errors++;
            end
            if (cache_set_req.data !== exp.data) begin
                $display("FAIL cache_set_req.data got %h expected %h",
                         cache_set_req.data, exp.data);
                errors++;
            end
        end
        fill_seen++;
    endtask

    task automatic check_rsp();
        get_rsp_t exp;
        req_tag_t t;
        t = icm_get_rsp.head.req_tag;
        if (prio_watch && t == prio_tag && fill_seen == prio_fill_base) begin
            $display("hit response came out before the waiting miss was filled");
            errors++;
        end
        if (exp_rsp_q[t].size() == 0) begin
            $display("unexpected response beat for tag %0d", t);
            errors++;
        end else begin
            exp = exp_rsp_q[t].pop_front();
            if (icm_get_rsp.head !== exp.head) begin
                $display("FAIL icm_get_rsp.head got %h expected %h",
                         icm_get_rsp.head, exp.head);
                errors++;
            end
            if (icm_get_rsp.data !== exp.data) begin
                $display("FAIL icm_get_rsp.data got %h expected %h",
                         icm_get_rsp.data, exp.data);
                errors++;
            end
            tag_busy[t] = exp_rsp_q[t].size() != 0;
        end
        rsp_seen++;
    endtask

    always @(posedge clk) begin
        if (!rst && cache_set_req_valid && cache_set_req_ready) begin
            check_fill();
        end
        if (!rst && icm_get_rsp_valid && icm_get_rsp_ready) begin
            check_rsp();
        end
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("timeout, run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // queue one part and, once its set is complete, the expected beats
    task automatic send_part(input logic use_miss, input req_tag_t tag,
                             input part_cnt_t cmax, input part_idx_t idx);
        get_req_head_t  h;
        hit_item_t      hi;
        cache_set_req_t fill;
        cache_entry_t   d;
        int             n;
        h.count_max   = cmax;
        h.count_index = idx;
        h.req_tag     = tag;
        h.phys_addr   = rand32();
        h.cache_addr  = cache_addr_t'(rand32());
        d = rand_entry();
        n = sent_n[tag];
        sent_head[tag][n] = h;
        sent_data[tag][n] = d;
        sent_n[tag]       = n + 1;
        tag_busy[tag]     = 1'b1;
        if (use_miss) begin
            fill.addr = h.cache_addr;
            fill.data = d;
            miss_q.push_back(h);
            mem_q.push_back(d);
            exp_fill_q.push_back(fill);
        end else begin
            hi.head = h;
            hi.data = d;
            hit_q.push_back(hi);
        end
        if (n + 1 == int'(cmax)) begin
            for (int k = 0; k < n + 1; k++) begin
                exp_rsp_q[tag].push_back(ref_beat(sent_head[tag], sent_data[tag], n + 1, k));
            end
            sent_n[tag] = 0;
        end
    endtask

    function automatic logic drained();
        logic d;
        d = hit_q.size() == 0 && miss_q.size() == 0 && mem_q.size() == 0
            && exp_fill_q.size() == 0;
        for (int t = 0; t < TAGS; t++) begin
            if (exp_rsp_q[t].size() != 0) begin
                d = 1'b0;
            end
        end
        return d;
    endfunction

    task automatic report_test(input int num, input string name, input int base);
        while (!drained()) begin
            @(negedge clk);
        end
        if (errors == base) begin
            $display("test %0d %s: passed", num, name);
        end else begin
            $display("test %0d %s: failed with %0d errors", num, name, errors - base);
        end
    endtask

    initial begin
        int          base;
        logic [31:0] r;
        req_tag_t    tag;
        part_cnt_t   cmax;
        part_idx_t   idx;
        logic        pend;
        logic        pend_miss;
        req_tag_t    pend_tag;
        part_idx_t   pend_idx;
        errors     = 0;
        rsp_seen   = 0;
        fill_seen  = 0;
        cycle_cnt  = 0;
        bp_en      = 1'b0;
        prio_watch = 1'b0;
        prio_tag   = '0;
        prio_fill_base = 0;
        for (int t = 0; t < TAGS; t++) begin
            sent_n[t]   = 0;
            tag_busy[t] = 1'b0;
        end
        drive_ports();
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;

        @(negedge clk);
        base = errors;
        if (req_hit_rd_en !== 1'b0 || req_miss_rd_en !== 1'b0 || icm_entry_rsp_ready !== 1'b0
            || cache_set_req_valid !== 1'b0 || icm_get_rsp_valid !== 1'b0) begin
            $display("control outputs not all low after reset");
            errors++;
        end
        repeat (10) @(negedge clk);
        report_test(1, "reset", base);

        base = errors;
        send_part(1'b0, 5'd3, 2'd1, 1'b0);
        report_test(2, "single hit", base);

        base = errors;
        send_part(1'b1, 5'd7, 2'd2, 1'b1);
        send_part(1'b1, 5'd7, 2'd2, 1'b0);
        report_test(3, "two-part miss out of order", base);

        // hit part merged first, then the miss part completes the tag
        base = errors;
        send_part(1'b0, 5'd12, 2'd2, 1'b0);
        while (hit_q.size() != 0) begin
            @(negedge clk);
        end
        send_part(1'b1, 5'd12, 2'd2, 1'b1);
        @(negedge clk);
        // hit on tag 10 and miss on tag 11 wait together, the miss goes first
        prio_watch     = 1'b1;
        prio_tag       = 5'd10;
        prio_fill_base = fill_seen + exp_fill_q.size();
        send_part(1'b0, 5'd10, 2'd1, 1'b0);
        send_part(1'b1, 5'd11, 2'd1, 1'b0);
        report_test(4, "mixed sources and miss priority", base);
        prio_watch = 1'b0;

        // tags 0..7 only so cleared slots get reused
        base  = errors;
        bp_en = 1'b1;
        pend  = 1'b0;
        for (int s = 0; s < RAND_SETS; s++) begin
            r   = rand32();
            tag = req_tag_t'(r % 8);
            while (tag_busy[tag]) begin
                @(negedge clk);
                r   = rand32();
                tag = req_tag_t'(r % 8);
            end
            cmax = r[8] ? 2'd2 : 2'd1;
            idx  = (cmax == 2'd2) ? part_idx_t'(r[9]) : 1'b0;
            send_part(r[10], tag, cmax, idx);
            if (pend) begin
                send_part(pend_miss, pend_tag, 2'd2, pend_idx);
                pend = 1'b0;
            end
            if (cmax == 2'd2 && r[11]) begin
                send_part(r[10], tag, cmax, ~idx);
            end else if (cmax == 2'd2) begin
                pend      = 1'b1;
                pend_miss = r[10];
                pend_tag  = tag;
                pend_idx  = ~idx;
            end
            repeat (r[13:12]) @(negedge clk);
        end
        if (pend) begin
            send_part(pend_miss, pend_tag, 2'd2, pend_idx);
        end
        report_test(5, "random back-pressure and interleaving", base);

        $display("summary: %0d response beats, %0d fills, %0d errors",
                 rsp_seen, fill_seen, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* icm_get_proc.f */
+incdir+dv
verilog/icm_cfg_pkg.sv
verilog/icm_get_pkg.sv
verilog/reorder_buffer.sv
verilog/get_proc_ctrl.sv
verilog/icm_get_proc.sv
dv/tb_icm_get_proc.sv

/* run_sim.sh */
#!/bin/sh
# build and run the ICM get thread testbench with Verilator
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_icm_get_proc -f icm_get_proc.f -o sim_tb > "$BUILD_LOG" 2>&1 \
    || { cat "$BUILD_LOG"; echo "build failed"; exit 1; }

./obj_dir/sim_tb > "$SIM_LOG" 2>&1
cat "$SIM_LOG"

grep -q "^PASS: all tests$" "$SIM_LOG" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
